/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_llc_front
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/llc_decode_if.sv */
`timescale 1ns/100ps

interface llc_decode_if
    import llc_pkg::*;
#(
    parameter int ADDR_BITS = llc_pkg::ADDR_BITS,
    parameter int SET_BITS  = llc_pkg::SET_BITS
) ();

    logic                          valid;
    decode_kind_t                  kind;
    logic [SET_BITS-1:0]           set;
    logic [ADDR_BITS-SET_BITS-1:0] tag;
    // lookup stage takes the decision this cycle
    logic                          accept;

    modport decoder (output valid, kind, set, tag, input accept);

    modport array (input valid, kind, set, tag, output accept);

    modport monitor (input valid, kind, set, tag, accept);

endinterface

/* common/llc_pkg.sv */
package llc_pkg;

    // default geometry, the top level passes its own values down
    localparam int ADDR_BITS = 16;
    localparam int SET_BITS  = 4;

    // line address, set index in the low bits
    typedef logic [ADDR_BITS-1:0] line_addr_t;

    typedef logic [SET_BITS-1:0] llc_set_t;

    // tag is whatever sits above the set index
    typedef logic [ADDR_BITS-SET_BITS-1:0] llc_tag_t;

    // what the decision register holds
    typedef enum logic [2:0] {
        KIND_NONE        = 3'd0,
        KIND_RST_SWEEP   = 3'd1,
        KIND_FLUSH_SWEEP = 3'd2,
        KIND_RSP         = 3'd3,
        KIND_REQ         = 3'd4,
        KIND_REQ_REPLAY  = 3'd5,
        KIND_DMA         = 3'd6
    } decode_kind_t;

endpackage

/* files.f */
+incdir+test
common/llc_pkg.sv
common/llc_decode_if.sv
input_decoder/input_decoder.sv
logic/llc_stall_regs.sv
logic/llc_tag_array.sv
logic/llc_front_top.sv
test/tb_llc_front.sv

/* input_decoder/input_decoder.sv */
`timescale 1ns/100ps

module input_decoder
    import llc_pkg::*;
#(
    parameter int ADDR_BITS = llc_pkg::ADDR_BITS,
    parameter int SET_BITS  = llc_pkg::SET_BITS
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_valid,
    input  logic                          cmd_flush,
    input  logic                          rsp_valid,
    input  logic [ADDR_BITS-1:0]          rsp_addr,
    input  logic                          req_valid,
    input  logic [ADDR_BITS-1:0]          req_addr,
    input  logic                          dma_valid,
    input  logic [ADDR_BITS-1:0]          dma_addr,
    input  logic                          rst_stall,
    input  logic                          flush_stall,
    input  logic                          req_stall,
    input  logic                          stalled_valid,
    input  logic [ADDR_BITS-SET_BITS-1:0] stalled_tag,
    input  logic [SET_BITS-1:0]           stalled_set,
    input  logic [SET_BITS-1:0]           sweep_set,
    output logic                          cmd_ready,
    output logic                          rsp_ready,
    output logic                          req_ready,
    output logic                          dma_ready,
    output logic                          start_rst,
    output logic                          start_flush,
    llc_decode_if.decoder                 dec
);

    localparam int TAG_W = ADDR_BITS - SET_BITS;

    logic                 transfer;
    logic                 slot_free;
    logic                 sweep_on_dec;
    logic                 sweep_last;
    logic                 rsp_busy;
    logic                 req_busy;
    logic                 dma_busy;
    logic                 rst_act;
    logic                 flush_act;
    logic                 req_open;
    logic                 cmd_pending;
    logic                 pick;
    decode_kind_t         pick_kind;
    logic [ADDR_BITS-1:0] pick_addr;
    logic [SET_BITS-1:0]  next_sweep;
    logic [SET_BITS-1:0]  pick_set;
    logic [TAG_W-1:0]     pick_tag;

    assign transfer  = dec.valid && dec.accept;
    assign slot_free = !dec.valid || dec.accept;

    assign sweep_on_dec = dec.valid
                          && (dec.kind == KIND_RST_SWEEP || dec.kind == KIND_FLUSH_SWEEP);
    assign sweep_last   = sweep_on_dec && (&dec.set);

    // channel already owns the decision register
    assign rsp_busy = dec.valid && dec.kind == KIND_RSP;
    assign req_busy = dec.valid && (dec.kind == KIND_REQ || dec.kind == KIND_REQ_REPLAY);
    assign dma_busy = dec.valid && dec.kind == KIND_DMA;

    // last sweep set leaving, so the stall is as good as cleared
    assign rst_act   = rst_stall && !sweep_last;
    assign flush_act = flush_stall && !sweep_last;

    // a request still in the register may yet miss
    assign req_open = !req_stall && !req_busy;

    // counter lags by one while a sweep sits in the register
    assign next_sweep = sweep_on_dec ? dec.set + 1'b1 : sweep_set;

    always_comb begin
        pick        = 1'b0;
        pick_kind   = KIND_NONE;
        pick_addr   = '0;
        start_rst   = 1'b0;
        start_flush = 1'b0;
        if (slot_free) begin
            if (rst_act) begin
                pick      = 1'b1;
                pick_kind = KIND_RST_SWEEP;
            end else if (flush_act) begin
                pick      = 1'b1;
                pick_kind = KIND_FLUSH_SWEEP;
            end else if (cmd_valid && !rst_stall && !flush_stall && !cmd_pending) begin
                // command only arms the sweep, no lookup of its own
                start_rst   = !cmd_flush;
                start_flush = cmd_flush;
            end else if (rsp_valid && !rsp_busy) begin
                pick      = 1'b1;
                pick_kind = KIND_RSP;
                pick_addr = rsp_addr;
            end else if (req_open && stalled_valid) begin
                pick      = 1'b1;
                pick_kind = KIND_REQ_REPLAY;
            end else if (req_open && req_valid) begin
                pick      = 1'b1;
                pick_kind = KIND_REQ;
                pick_addr = req_addr;
            end else if (req_open && dma_valid && !dma_busy) begin
                pick      = 1'b1;
                pick_kind = KIND_DMA;
                pick_addr = dma_addr;
            end
        end
    end

    // split the address, sweeps and replays bring their own line
    always_comb begin
        pick_set = pick_addr[SET_BITS-1:0];
        pick_tag = pick_addr[ADDR_BITS-1:SET_BITS];
        if (pick_kind == KIND_RST_SWEEP || pick_kind == KIND_FLUSH_SWEEP) begin
            pick_set = next_sweep;
            pick_tag = '0;
        end else if (pick_kind == KIND_REQ_REPLAY) begin
            pick_set = stalled_set;
            pick_tag = stalled_tag;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dec.valid   <= 1'b0;
            dec.kind    <= KIND_NONE;
            cmd_pending <= 1'b0;
        end else begin
            if (slot_free) begin
                dec.valid <= pick;
                dec.kind  <= pick_kind;
            end
            if (start_rst || start_flush) begin
                cmd_pending <= 1'b1;
            end else if (cmd_ready) begin
                cmd_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot_free && pick) begin
            dec.set <= pick_set;
            dec.tag <= pick_tag;
        end
    end

    // command completes with its last sweep set
    assign cmd_ready = cmd_pending && sweep_last && transfer;
    assign rsp_ready = transfer && dec.kind == KIND_RSP;
    assign req_ready = transfer && dec.kind == KIND_REQ;
    assign dma_ready = transfer && dec.kind == KIND_DMA;

    a_one_ready: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({cmd_ready, rsp_ready, req_ready, dma_ready}));

    a_dec_hold: assert property (@(posedge clk) disable iff (!rst)
        dec.valid && !dec.accept |=> dec.valid && $stable(dec.kind)
                                     && $stable(dec.set) && $stable(dec.tag));

endmodule

/* logic/llc_front_top.sv */
`timescale 1ns/100ps

module llc_front_top
    import llc_pkg::*;
#(
    parameter int ADDR_BITS = llc_pkg::ADDR_BITS,
    parameter int SET_BITS  = llc_pkg::SET_BITS
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_valid,
    input  logic                          cmd_flush,
    output logic                          cmd_ready,
    input  logic                          rsp_valid,
    input  logic [ADDR_BITS-1:0]          rsp_addr,
    output logic                          rsp_ready,
    input  logic                          req_valid,
    input  logic [ADDR_BITS-1:0]          req_addr,
    output logic                          req_ready,
    input  logic                          dma_valid,
    input  logic [ADDR_BITS-1:0]          dma_addr,
    output logic                          dma_ready,
    output logic                          out_valid,
    output decode_kind_t                  out_kind,
    output logic [SET_BITS-1:0]           out_set,
    output logic [ADDR_BITS-SET_BITS-1:0] out_tag,
    output logic                          out_hit,
    input  logic                          out_ready
);

    logic                          start_rst;
    logic                          start_flush;
    logic                          rst_stall;
    logic                          flush_stall;
    logic                          req_stall;
    logic                          stalled_valid;
    logic [ADDR_BITS-SET_BITS-1:0] stalled_tag;
    logic [SET_BITS-1:0]           stalled_set;
    logic [SET_BITS-1:0]           sweep_set;
    logic                          miss;

    llc_decode_if #(.ADDR_BITS(ADDR_BITS), .SET_BITS(SET_BITS)) dec_if ();

    input_decoder #(.ADDR_BITS(ADDR_BITS), .SET_BITS(SET_BITS)) decoder_i (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_flush(cmd_flush),
        .rsp_valid(rsp_valid), .rsp_addr(rsp_addr),
        .req_valid(req_valid), .req_addr(req_addr),
        .dma_valid(dma_valid), .dma_addr(dma_addr),
        .rst_stall(rst_stall), .flush_stall(flush_stall), .req_stall(req_stall),
        .stalled_valid(stalled_valid), .stalled_tag(stalled_tag),
        .stalled_set(stalled_set), .sweep_set(sweep_set),
        .cmd_ready(cmd_ready), .rsp_ready(rsp_ready),
        .req_ready(req_ready), .dma_ready(dma_ready),
        .start_rst(start_rst), .start_flush(start_flush),
        .dec(dec_if.decoder)
    );

    llc_stall_regs #(.ADDR_BITS(ADDR_BITS), .SET_BITS(SET_BITS)) stall_i (
        .clk(clk), .rst(rst),
        .start_rst(start_rst), .start_flush(start_flush),
        .dec(dec_if.monitor), .miss(miss),
        .rst_stall(rst_stall), .flush_stall(flush_stall), .req_stall(req_stall),
        .stalled_valid(stalled_valid), .stalled_tag(stalled_tag),
        .stalled_set(stalled_set), .sweep_set(sweep_set)
    );

    llc_tag_array #(.ADDR_BITS(ADDR_BITS), .SET_BITS(SET_BITS)) array_i (
        .clk(clk), .rst(rst),
        .dec(dec_if.array), .out_ready(out_ready),
        .out_valid(out_valid), .out_kind(out_kind), .out_set(out_set),
        .out_tag(out_tag), .out_hit(out_hit), .miss(miss)
    );

endmodule

/* logic/llc_stall_regs.sv */
`timescale 1ns/100ps

module llc_stall_regs
    import llc_pkg::*;
#(
    parameter int ADDR_BITS = llc_pkg::ADDR_BITS,
    parameter int SET_BITS  = llc_pkg::SET_BITS
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_rst,
    input  logic                          start_flush,
    llc_decode_if.monitor                 dec,
    input  logic                          miss,
    output logic                          rst_stall,
    output logic                          flush_stall,
    output logic                          req_stall,
    output logic                          stalled_valid,
    output logic [ADDR_BITS-SET_BITS-1:0] stalled_tag,
    output logic [SET_BITS-1:0]           stalled_set,
    output logic [SET_BITS-1:0]           sweep_set
);

    logic transfer;
    logic sweep_xfer;
    logic sweep_end;
    logic rsp_match;
    logic replay_xfer;

    assign transfer    = dec.valid && dec.accept;
    assign sweep_xfer  = transfer
                         && (dec.kind == KIND_RST_SWEEP || dec.kind == KIND_FLUSH_SWEEP);
    assign sweep_end   = sweep_xfer && (&sweep_set);
    assign replay_xfer = transfer && dec.kind == KIND_REQ_REPLAY;

    // fill for the parked line releases the request path
    assign rsp_match = transfer && dec.kind == KIND_RSP
                       && dec.set == stalled_set && dec.tag == stalled_tag;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall   <= 1'b0;
            flush_stall <= 1'b0;
            sweep_set   <= '0;
        end else begin
            if (start_rst) begin
                rst_stall <= 1'b1;
            end else if (sweep_end && dec.kind == KIND_RST_SWEEP) begin
                rst_stall <= 1'b0;
            end
            if (start_flush) begin
                flush_stall <= 1'b1;
            end else if (sweep_end && dec.kind == KIND_FLUSH_SWEEP) begin
                flush_stall <= 1'b0;
            end
            // wraps back to zero after the last set
            if (start_rst || start_flush) begin
                sweep_set <= '0;
            end else if (sweep_xfer) begin
                sweep_set <= sweep_set + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_stall     <= 1'b0;
            stalled_valid <= 1'b0;
        end else if (miss) begin
            req_stall     <= 1'b1;
            stalled_valid <= 1'b1;
        end else begin
            if (req_stall && rsp_match) begin
                req_stall <= 1'b0;
            end
            if (replay_xfer) begin
                stalled_valid <= 1'b0;
            end
        end
    end

    // parked line
    always_ff @(posedge clk) begin
        if (miss) begin
            stalled_tag <= dec.tag;
            stalled_set <= dec.set;
        end
    end

    a_one_sweep: assert property (@(posedge clk) disable iff (!rst)
        !(rst_stall && flush_stall));

    a_replay_ok: assert property (@(posedge clk) disable iff (!rst)
        replay_xfer |-> stalled_valid && !req_stall);

endmodule

/* logic/llc_tag_array.sv */
`timescale 1ns/100ps

module llc_tag_array
    import llc_pkg::*;
#(
    parameter int ADDR_BITS = llc_pkg::ADDR_BITS,
    parameter int SET_BITS  = llc_pkg::SET_BITS
) (
    input  logic                          clk,
    input  logic                          rst,
    llc_decode_if.array                   dec,
    input  logic                          out_ready,
    output logic                          out_valid,
    output decode_kind_t                  out_kind,
    output logic [SET_BITS-1:0]           out_set,
    output logic [ADDR_BITS-SET_BITS-1:0] out_tag,
    output logic                          out_hit,
    output logic                          miss
);

    localparam int SETS = 1 << SET_BITS;

    logic [ADDR_BITS-SET_BITS-1:0] tag_mem [SETS];
    logic [SETS-1:0]               valid_q;
    logic                          transfer;
    logic                          is_sweep;
    logic                          is_fill;
    logic                          hit;

    // result register empty or draining
    assign dec.accept = !out_valid || out_ready;
    assign transfer   = dec.valid && dec.accept;

    assign is_sweep = dec.kind == KIND_RST_SWEEP || dec.kind == KIND_FLUSH_SWEEP;
    assign is_fill  = dec.kind == KIND_RSP;

    // state before any fill of this cycle
    assign hit  = valid_q[dec.set] && (tag_mem[dec.set] == dec.tag);
    assign miss = transfer && dec.kind == KIND_REQ && !hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (transfer) begin
            if (is_fill) begin
                valid_q[dec.set] <= 1'b1;
            end else if (is_sweep) begin
                valid_q[dec.set] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (transfer && is_fill) begin
            tag_mem[dec.set] <= dec.tag;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (dec.accept) begin
            out_valid <= dec.valid;
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (transfer) begin
            out_kind <= dec.kind;
            out_set  <= dec.set;
            out_tag  <= dec.tag;
            out_hit  <= hit && !is_sweep;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_kind) && $stable(out_set)
                                    && $stable(out_tag) && $stable(out_hit));

endmodule

/* test/tb_llc_tasks.svh */
task automatic send_cmd(input logic flush);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_flush <= flush;
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    @(posedge clk);
    cmd_valid <= 1'b0;
endtask

task automatic send_rsp(input line_addr_t a);
    @(posedge clk);
    rsp_valid <= 1'b1;
    rsp_addr  <= a;
    @(negedge clk);
    while (!rsp_ready) @(negedge clk);
    @(posedge clk);
    rsp_valid <= 1'b0;
endtask

task automatic send_req(input line_addr_t a);
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr  <= a;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    req_valid <= 1'b0;
endtask

task automatic send_dma(input line_addr_t a);
    @(posedge clk);
    dma_valid <= 1'b1;
    dma_addr  <= a;
    @(negedge clk);
    while (!dma_ready) @(negedge clk);
    @(posedge clk);
    dma_valid <= 1'b0;
endtask

task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk);
endtask

task automatic check_hit(input int idx, input logic exp);
    assert (hit_log[idx] == exp) else report_error($sformatf(
        "MISMATCH at %0t: out_hit of result %0d expected %0b got %0b", $time, idx, exp,
        hit_log[idx]));
endtask

// dma held back until the command is done
task automatic test_reset_sweep();
    logic cmd_done;
    cmd_done = 1'b0;
    for (int i = 0; i < SETS; i++) begin
        push_exp(KIND_RST_SWEEP, line_addr_t'(i));
    end
    push_exp(KIND_DMA, 16'h0a31);
    fork
        begin
            send_cmd(1'b0);
            // at most the last sweep set and the dma still to come
            assert (exp_q.size() <= 2) else report_error("cmd_ready before the sweep was done");
            cmd_done = 1'b1;
        end
        send_dma(16'h0a31);
        while (!cmd_done) begin
            @(negedge clk);
            assert (!dma_ready || cmd_done) else report_error("dma accepted during sweep");
        end
    join
    wait_drain();
endtask

task automatic test_miss_replay();
    hit_log.delete();
    push_exp(KIND_REQ, LINE_A);
    send_req(LINE_A);
    push_exp(KIND_RSP, LINE_A);
    push_exp(KIND_REQ_REPLAY, LINE_A);
    push_exp(KIND_REQ, LINE_A);
    fork
        send_req(LINE_A);
        begin
            repeat (20) begin
                @(negedge clk);
                assert (!req_ready) else report_error("request accepted while stalled");
            end
            send_rsp(LINE_A);
        end
    join
    wait_drain();
    check_hit(0, 1'b0);
    check_hit(1, 1'b0);
    check_hit(2, 1'b1);
endtask

// response wins when both arrive in one cycle
task automatic test_rsp_before_req();
    push_exp(KIND_RSP, LINE_B);
    push_exp(KIND_REQ, LINE_B);
    fork
        send_rsp(LINE_B);
        send_req(LINE_B);
    join
    wait_drain();
endtask

task automatic test_dma_blocked();
    push_exp(KIND_REQ, LINE_C);
    send_req(LINE_C);
    push_exp(KIND_RSP, LINE_C);
    push_exp(KIND_REQ_REPLAY, LINE_C);
    push_exp(KIND_DMA, LINE_A);
    fork
        send_dma(LINE_A);
        begin
            repeat (20) begin
                @(negedge clk);
                assert (!dma_ready) else report_error("dma accepted while request stalled");
            end
            send_rsp(LINE_C);
        end
    join
    wait_drain();
endtask

task automatic test_backpressure();
    line_addr_t a;
    line_addr_t d;
    @(posedge clk);
    gap_mode <= 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
        a = rand_bits(ADDR_BITS);
        d = rand_bits(ADDR_BITS);
        push_exp(KIND_RSP, a);
        push_exp(KIND_REQ, a);
        push_exp(KIND_DMA, d);
        send_rsp(a);
        send_req(a);
        send_dma(d);
    end
    wait_drain();
    @(posedge clk);
    gap_mode <= 1'b0;
endtask

task automatic test_flush();
    for (int i = 0; i < SETS; i++) begin
        push_exp(KIND_FLUSH_SWEEP, line_addr_t'(i));
    end
    send_cmd(1'b1);
    wait_drain();
    push_exp(KIND_REQ, LINE_A);
    send_req(LINE_A);
    wait_drain();
    check_hit(hit_log.size() - 1, 1'b0);
endtask

/* test/tb_llc_front.sv */
`timescale 1ns/100ps

module tb_llc_front
    import llc_pkg::*;
();

    localparam int SETS            = 1 << SET_BITS;
    localparam int RESET_CYCLES    = 10;
    localparam int SWEEP_CYCLES    = 24;
    localparam int STALL_CYCLES    = 40;
    localparam int N_RAND          = 8;
    localparam int GAP_ITEM_CYCLES = 10;
    // four times the rough length of all tests together
    localparam int TIMEOUT_CYCLES  = 4 * (RESET_CYCLES + 2 * SWEEP_CYCLES + 3 * STALL_CYCLES
                                          + N_RAND * 3 * GAP_ITEM_CYCLES);

    localparam line_addr_t LINE_A = 16'h1235;
    localparam line_addr_t LINE_B = 16'h2c49;
    localparam line_addr_t LINE_C = 16'h4ab7;

    typedef struct packed {
        decode_kind_t kind;
        llc_set_t     set;
        llc_tag_t     tag;
    } exp_t;

    logic         clk = 1'b0;
    logic         rst;
    logic         cmd_valid;
    logic         cmd_flush;
    logic         cmd_ready;
    logic         rsp_valid;
    line_addr_t   rsp_addr;
    logic         rsp_ready;
    logic         req_valid;
    line_addr_t   req_addr;
    logic         req_ready;
    logic         dma_valid;
    line_addr_t   dma_addr;
    logic         dma_ready;
    logic         out_valid;
    decode_kind_t out_kind;
    llc_set_t     out_set;
    llc_tag_t     out_tag;
    logic         out_hit;
    logic         out_ready = 1'b1;

    exp_t         exp_q[$];
    logic         hit_log[$];
    int           error_count  = 0;
    int           cycle_count  = 0;
    logic         gap_mode = 1'b0;
    logic [15:0]  gap_lfsr = 16'd89;
    logic [15:0]  addr_lfsr = 16'd89;

    // reference tag model
    llc_tag_t         model_tag [SETS];
    logic [SETS-1:0]  model_valid = '0;

    llc_front_top #(.ADDR_BITS(ADDR_BITS), .SET_BITS(SET_BITS)) dut_i (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_flush(cmd_flush), .cmd_ready(cmd_ready),
        .rsp_valid(rsp_valid), .rsp_addr(rsp_addr), .rsp_ready(rsp_ready),
        .req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
        .dma_valid(dma_valid), .dma_addr(dma_addr), .dma_ready(dma_ready),
        .out_valid(out_valid), .out_kind(out_kind), .out_set(out_set),
        .out_tag(out_tag), .out_hit(out_hit), .out_ready(out_ready)
    );

    always #10 clk = ~clk;

    task automatic report_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            report_error($sformatf("timeout after %0d cycles, a handshake never completed",
                                   cycle_count));
        end
    end

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic line_addr_t rand_bits(input int n);
        line_addr_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            addr_lfsr = lfsr_step(addr_lfsr);
            v = {v[ADDR_BITS-2:0], addr_lfsr[0]};
        end
        return v;
    endfunction

    // back-pressure gaps
    always @(posedge clk) begin
        if (gap_mode) begin
            gap_lfsr = lfsr_step(gap_lfsr);
            out_ready <= gap_lfsr[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    task automatic check_result();
        exp_t e;
        logic sweep;
        logic exp_hit;
        if (exp_q.size() == 0) begin
            report_error($sformatf("result at %0t with no item pending", $time));
        end else begin
            e = exp_q.pop_front();
            sweep = e.kind == KIND_RST_SWEEP || e.kind == KIND_FLUSH_SWEEP;
            exp_hit = !sweep && model_valid[e.set] && model_tag[e.set] == e.tag;
            assert (out_kind == e.kind) else report_error($sformatf(
                "MISMATCH at %0t: out_kind expected %s got %s", $time, e.kind.name(),
                out_kind.name()));
            assert (out_set == e.set) else report_error($sformatf(
                "MISMATCH at %0t: out_set expected %0d got %0d", $time, e.set, out_set));
            assert (sweep || out_tag == e.tag) else report_error($sformatf(
                "MISMATCH at %0t: out_tag expected %h got %h", $time, e.tag, out_tag));
            assert (out_hit == exp_hit) else report_error($sformatf(
                "MISMATCH at %0t: out_hit expected %0b got %0b", $time, exp_hit, out_hit));
            if (e.kind == KIND_RSP) begin
                model_valid[e.set] = 1'b1;
                model_tag[e.set]   = e.tag;
            end else if (sweep) begin
                model_valid[e.set] = 1'b0;
            end
            hit_log.push_back(out_hit);
        end
    endtask

    always @(negedge clk) begin
        if (rst && out_valid && out_ready) begin
            check_result();
        end
    end

    function automatic void push_exp(input decode_kind_t k, input line_addr_t a);
        exp_q.push_back('{kind: k, set: a[SET_BITS-1:0], tag: a[ADDR_BITS-1:SET_BITS]});
    endfunction

    `include "tb_llc_tasks.svh"

    initial begin
        rst       = 1'b0;
        cmd_valid = 1'b0;
        cmd_flush = 1'b0;
        rsp_valid = 1'b0;
        rsp_addr  = '0;
        req_valid = 1'b0;
        req_addr  = '0;
        dma_valid = 1'b0;
        dma_addr  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        assert (!out_valid && !cmd_ready && !rsp_ready && !req_ready && !dma_ready)
            else report_error("outputs not idle after reset");
        test_reset_sweep();
        test_miss_replay();
        test_rsp_before_req();
        test_dma_blocked();
        test_backpressure();
        test_flush();
        // no stray result once every expected item is seen
        repeat (4) @(negedge clk);
        assert (!out_valid) else report_error("result appeared after the last expected item");
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
